//--- source/tlb_pkg.sv
package tlb_pkg;

    // table size
    localparam int tlb_num     = 16;
    localparam int tlb_index_w = $clog2(tlb_num);

    // one entry holds an even/odd page pair:
    //   vpn2  asid  g  pfn0 c0 d0 v0  pfn1 c1 d1 v1
    //    19     8   1   20   3  1  1   20   3  1  1

    // entry number
    typedef logic [tlb_index_w-1:0] tlb_index_t;

    // virtual page pair number
    typedef logic [18:0] vpn2_t;

    // address space id
    typedef logic [7:0] asid_t;

    // physical frame number
    typedef logic [19:0] pfn_t;

    // cache attribute
    typedef logic [2:0] cache_attr_t;

    // one bit per entry, write enables and match flags
    typedef logic [tlb_num-1:0] entry_mask_t;

endpackage

//--- source/tlb_fill_if.sv
`timescale 1ns/1ns

// write broadcast from the fill port to all entries
interface tlb_fill_if
    import tlb_pkg::*;
();

    entry_mask_t wen;
    vpn2_t       vpn2;
    asid_t       asid;
    logic        g;
    pfn_t        pfn0;
    cache_attr_t c0;
    logic        d0;
    logic        v0;
    pfn_t        pfn1;
    cache_attr_t c1;
    logic        d1;
    logic        v1;

    modport fill (
        output wen, vpn2, asid, g,
        output pfn0, c0, d0, v0,
        output pfn1, c1, d1, v1
    );

    modport entry (
        input wen, vpn2, asid, g,
        input pfn0, c0, d0, v0,
        input pfn1, c1, d1, v1
    );

endinterface

//--- source/tlb_slot_if.sv
`timescale 1ns/1ns

// stored fields and match flags of one entry
interface tlb_slot_if
    import tlb_pkg::*;
();

    vpn2_t       vpn2;
    asid_t       asid;
    logic        g;
    pfn_t        pfn0;
    cache_attr_t c0;
    logic        d0;
    logic        v0;
    pfn_t        pfn1;
    cache_attr_t c1;
    logic        d1;
    logic        v1;
    logic        match0;
    logic        match1;

    modport entry (
        output vpn2, asid, g,
        output pfn0, c0, d0, v0,
        output pfn1, c1, d1, v1,
        output match0, match1
    );

    modport select (
        input vpn2, asid, g,
        input pfn0, c0, d0, v0,
        input pfn1, c1, d1, v1,
        input match0, match1
    );

endinterface

//--- source/tlb_fill_port.sv
`timescale 1ns/1ns

module tlb_fill_port
    import tlb_pkg::*;
(
    input  logic        we,
    input  tlb_index_t  w_index,
    input  vpn2_t       w_vpn2,
    input  asid_t       w_asid,
    input  logic        w_g,
    input  pfn_t        w_pfn0,
    input  cache_attr_t w_c0,
    input  logic        w_d0,
    input  logic        w_v0,
    input  pfn_t        w_pfn1,
    input  cache_attr_t w_c1,
    input  logic        w_d1,
    input  logic        w_v1,
    tlb_fill_if.fill    fill
);

    // one-hot enable, zero when we is low
    assign fill.wen = entry_mask_t'(we) << w_index;

    // data goes to every entry, only the enabled one loads it
    assign fill.vpn2 = w_vpn2;
    assign fill.asid = w_asid;
    assign fill.g    = w_g;
    assign fill.pfn0 = w_pfn0;
    assign fill.c0   = w_c0;
    assign fill.d0   = w_d0;
    assign fill.v0   = w_v0;
    assign fill.pfn1 = w_pfn1;
    assign fill.c1   = w_c1;
    assign fill.d1   = w_d1;
    assign fill.v1   = w_v1;

endmodule

//--- source/tlb_entry.sv
`timescale 1ns/1ns

module tlb_entry
    import tlb_pkg::*;
#(
    parameter int unsigned slot_id = 0
) (
    input  logic      clk,
    input  logic      rst,
    tlb_fill_if.entry fill,
    input  vpn2_t     s0_vpn2,
    input  vpn2_t     s1_vpn2,
    input  asid_t     s0_asid,
    input  asid_t     s1_asid,
    tlb_slot_if.entry slot
);

    vpn2_t       ent_vpn2;
    asid_t       ent_asid;
    logic        ent_g;
    pfn_t        ent_pfn0;
    cache_attr_t ent_c0;
    logic        ent_d0;
    logic        ent_v0;
    pfn_t        ent_pfn1;
    cache_attr_t ent_c1;
    logic        ent_d1;
    logic        ent_v1;

    always_ff @(posedge clk) begin
        if (!rst) begin
            ent_vpn2 <= '0;
            ent_asid <= '0;
            ent_g    <= 1'b0;
            ent_pfn0 <= '0;
            ent_c0   <= '0;
            ent_d0   <= 1'b0;
            ent_v0   <= 1'b0;
            ent_pfn1 <= '0;
            ent_c1   <= '0;
            ent_d1   <= 1'b0;
            ent_v1   <= 1'b0;
        end else if (fill.wen[slot_id]) begin
            ent_vpn2 <= fill.vpn2;
            ent_asid <= fill.asid;
            ent_g    <= fill.g;
            ent_pfn0 <= fill.pfn0;
            ent_c0   <= fill.c0;
            ent_d0   <= fill.d0;
            ent_v0   <= fill.v0;
            ent_pfn1 <= fill.pfn1;
            ent_c1   <= fill.c1;
            ent_d1   <= fill.d1;
            ent_v1   <= fill.v1;
        end
    end

    // global entries ignore the asid
    assign slot.match0 = (s0_vpn2 == ent_vpn2) && ((s0_asid == ent_asid) || ent_g);
    assign slot.match1 = (s1_vpn2 == ent_vpn2) && ((s1_asid == ent_asid) || ent_g);

    assign slot.vpn2 = ent_vpn2;
    assign slot.asid = ent_asid;
    assign slot.g    = ent_g;
    assign slot.pfn0 = ent_pfn0;
    assign slot.c0   = ent_c0;
    assign slot.d0   = ent_d0;
    assign slot.v0   = ent_v0;
    assign slot.pfn1 = ent_pfn1;
    assign slot.c1   = ent_c1;
    assign slot.d1   = ent_d1;
    assign slot.v1   = ent_v1;

endmodule

//--- source/tlb_hit_select.sv
`timescale 1ns/1ns

module tlb_hit_select
    import tlb_pkg::*;
(
    tlb_slot_if.select  slots [tlb_num],
    input  logic        s0_odd_page,
    input  logic        s1_odd_page,
    input  tlb_index_t  r_index,

    output logic        s0_found,
    output tlb_index_t  s0_index,
    output pfn_t        s0_pfn,
    output cache_attr_t s0_c,
    output logic        s0_d,
    output logic        s0_v,

    output logic        s1_found,
    output tlb_index_t  s1_index,
    output pfn_t        s1_pfn,
    output cache_attr_t s1_c,
    output logic        s1_d,
    output logic        s1_v,

    output vpn2_t       r_vpn2,
    output asid_t       r_asid,
    output logic        r_g,
    output pfn_t        r_pfn0,
    output cache_attr_t r_c0,
    output logic        r_d0,
    output logic        r_v0,
    output pfn_t        r_pfn1,
    output cache_attr_t r_c1,
    output logic        r_d1,
    output logic        r_v1
);

    entry_mask_t match0;
    entry_mask_t match1;
    vpn2_t       vpn2_a [tlb_num];
    asid_t       asid_a [tlb_num];
    logic        g_a    [tlb_num];
    pfn_t        pfn0_a [tlb_num];
    cache_attr_t c0_a   [tlb_num];
    logic        d0_a   [tlb_num];
    logic        v0_a   [tlb_num];
    pfn_t        pfn1_a [tlb_num];
    cache_attr_t c1_a   [tlb_num];
    logic        d1_a   [tlb_num];
    logic        v1_a   [tlb_num];

    // interface arrays only take constant indices, so flatten them here
    for (genvar i = 0; i < tlb_num; i++) begin : g_gather
        assign match0[i] = slots[i].match0;
        assign match1[i] = slots[i].match1;
        assign vpn2_a[i] = slots[i].vpn2;
        assign asid_a[i] = slots[i].asid;
        assign g_a[i]    = slots[i].g;
        assign pfn0_a[i] = slots[i].pfn0;
        assign c0_a[i]   = slots[i].c0;
        assign d0_a[i]   = slots[i].d0;
        assign v0_a[i]   = slots[i].v0;
        assign pfn1_a[i] = slots[i].pfn1;
        assign c1_a[i]   = slots[i].c1;
        assign d1_a[i]   = slots[i].d1;
        assign v1_a[i]   = slots[i].v1;
    end

    // OR over all matching entries, a miss gives zeros
    function automatic void merge_hits(
        input  entry_mask_t match,
        input  logic        odd_page,
        output tlb_index_t  index,
        output pfn_t        pfn,
        output cache_attr_t c,
        output logic        d,
        output logic        v
    );
        index = '0;
        pfn   = '0;
        c     = '0;
        d     = 1'b0;
        v     = 1'b0;
        for (int i = 0; i < tlb_num; i++) begin
            if (match[i]) begin
                index |= tlb_index_t'(i);
                pfn   |= odd_page ? pfn1_a[i] : pfn0_a[i];
                c     |= odd_page ? c1_a[i] : c0_a[i];
                d     |= odd_page ? d1_a[i] : d0_a[i];
                v     |= odd_page ? v1_a[i] : v0_a[i];
            end
        end
    endfunction

    always_comb begin
        merge_hits(match0, s0_odd_page, s0_index, s0_pfn, s0_c, s0_d, s0_v);
        merge_hits(match1, s1_odd_page, s1_index, s1_pfn, s1_c, s1_d, s1_v);
    end

    assign s0_found = |match0;
    assign s1_found = |match1;

    // indexed read
    assign r_vpn2 = vpn2_a[r_index];
    assign r_asid = asid_a[r_index];
    assign r_g    = g_a[r_index];
    assign r_pfn0 = pfn0_a[r_index];
    assign r_c0   = c0_a[r_index];
    assign r_d0   = d0_a[r_index];
    assign r_v0   = v0_a[r_index];
    assign r_pfn1 = pfn1_a[r_index];
    assign r_c1   = c1_a[r_index];
    assign r_d1   = d1_a[r_index];
    assign r_v1   = v1_a[r_index];

endmodule

//--- source/tlb.sv
`timescale 1ns/1ns

module tlb
    import tlb_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // search port 0
    input  vpn2_t       s0_vpn2,
    input  logic        s0_odd_page,
    input  asid_t       s0_asid,
    output logic        s0_found,
    output tlb_index_t  s0_index,
    output pfn_t        s0_pfn,
    output cache_attr_t s0_c,
    output logic        s0_d,
    output logic        s0_v,

    // search port 1
    input  vpn2_t       s1_vpn2,
    input  logic        s1_odd_page,
    input  asid_t       s1_asid,
    output logic        s1_found,
    output tlb_index_t  s1_index,
    output pfn_t        s1_pfn,
    output cache_attr_t s1_c,
    output logic        s1_d,
    output logic        s1_v,

    // write port
    input  logic        we,
    input  tlb_index_t  w_index,
    input  vpn2_t       w_vpn2,
    input  asid_t       w_asid,
    input  logic        w_g,
    input  pfn_t        w_pfn0,
    input  cache_attr_t w_c0,
    input  logic        w_d0,
    input  logic        w_v0,
    input  pfn_t        w_pfn1,
    input  cache_attr_t w_c1,
    input  logic        w_d1,
    input  logic        w_v1,

    // read port
    input  tlb_index_t  r_index,
    output vpn2_t       r_vpn2,
    output asid_t       r_asid,
    output logic        r_g,
    output pfn_t        r_pfn0,
    output cache_attr_t r_c0,
    output logic        r_d0,
    output logic        r_v0,
    output pfn_t        r_pfn1,
    output cache_attr_t r_c1,
    output logic        r_d1,
    output logic        r_v1
);

    tlb_fill_if fill_bus ();
    tlb_slot_if slot [tlb_num] ();

    tlb_fill_port u_fill_port (
        .we      (we),
        .w_index (w_index),
        .w_vpn2  (w_vpn2),
        .w_asid  (w_asid),
        .w_g     (w_g),
        .w_pfn0  (w_pfn0),
        .w_c0    (w_c0),
        .w_d0    (w_d0),
        .w_v0    (w_v0),
        .w_pfn1  (w_pfn1),
        .w_c1    (w_c1),
        .w_d1    (w_d1),
        .w_v1    (w_v1),
        .fill    (fill_bus)
    );

    for (genvar i = 0; i < tlb_num; i++) begin : g_entry
        tlb_entry #(
            .slot_id (i)
        ) u_entry (
            .clk     (clk),
            .rst     (rst),
            .fill    (fill_bus),
            .s0_vpn2 (s0_vpn2),
            .s1_vpn2 (s1_vpn2),
            .s0_asid (s0_asid),
            .s1_asid (s1_asid),
            .slot    (slot[i])
        );
    end

    tlb_hit_select u_hit_select (
        .slots       (slot),
        .s0_odd_page (s0_odd_page),
        .s1_odd_page (s1_odd_page),
        .r_index     (r_index),
        .s0_found    (s0_found),
        .s0_index    (s0_index),
        .s0_pfn      (s0_pfn),
        .s0_c        (s0_c),
        .s0_d        (s0_d),
        .s0_v        (s0_v),
        .s1_found    (s1_found),
        .s1_index    (s1_index),
        .s1_pfn      (s1_pfn),
        .s1_c        (s1_c),
        .s1_d        (s1_d),
        .s1_v        (s1_v),
        .r_vpn2      (r_vpn2),
        .r_asid      (r_asid),
        .r_g         (r_g),
        .r_pfn0      (r_pfn0),
        .r_c0        (r_c0),
        .r_d0        (r_d0),
        .r_v0        (r_v0),
        .r_pfn1      (r_pfn1),
        .r_c1        (r_c1),
        .r_d1        (r_d1),
        .r_v1        (r_v1)
    );

endmodule

//--- include/tlb_ref_model.svh
`ifndef TLB_REF_MODEL_SVH
`define TLB_REF_MODEL_SVH

// shadow copy of one entry, field order as on the read port
typedef struct packed {
    vpn2_t       vpn2;
    asid_t       asid;
    logic        g;
    pfn_t        pfn0;
    cache_attr_t c0;
    logic        d0;
    logic        v0;
    pfn_t        pfn1;
    cache_attr_t c1;
    logic        d1;
    logic        v1;
} ref_entry_t;

// {found, index, pfn, c, d, v}
typedef logic [29:0] ref_hit_t;

ref_entry_t shadow [tlb_num];

function automatic void clear_shadow();
    for (int i = 0; i < tlb_num; i++) begin
        shadow[i] = '0;
    end
endfunction

// vpn2 must match, asid too unless the entry is global
function automatic ref_hit_t expect_search(input vpn2_t vpn2, input asid_t asid,
                                           input logic odd_page);
    logic        found;
    tlb_index_t  index;
    logic [24:0] half;
    logic [24:0] merged;
    found  = 1'b0;
    index  = '0;
    merged = '0;
    for (int i = 0; i < tlb_num; i++) begin
        if (shadow[i].vpn2 == vpn2 && (shadow[i].asid == asid || shadow[i].g)) begin
            half = odd_page ? {shadow[i].pfn1, shadow[i].c1, shadow[i].d1, shadow[i].v1}
                            : {shadow[i].pfn0, shadow[i].c0, shadow[i].d0, shadow[i].v0};
            found  = 1'b1;
            index  = index | tlb_index_t'(i);
            merged = merged | half;
        end
    end
    return {found, index, merged};
endfunction

`endif

//--- sim/tlb_tb.sv
`timescale 1ns/1ns

module tlb_tb
    import tlb_pkg::*;
();

    logic        clk = 1'b0;
    logic        rst;
    vpn2_t       s0_vpn2, s1_vpn2, w_vpn2, r_vpn2;
    asid_t       s0_asid, s1_asid, w_asid, r_asid;
    logic        s0_odd_page, s1_odd_page;
    logic        s0_found, s1_found;
    tlb_index_t  s0_index, s1_index, w_index, r_index;
    pfn_t        s0_pfn, s1_pfn, w_pfn0, w_pfn1, r_pfn0, r_pfn1;
    cache_attr_t s0_c, s1_c, w_c0, w_c1, r_c0, r_c1;
    logic        s0_d, s0_v, s1_d, s1_v;
    logic        we, w_g, w_d0, w_v0, w_d1, w_v1;
    logic        r_g, r_d0, r_v0, r_d1, r_v1;
    integer      seed = 12588;
    vpn2_t       key_vpn2;
    asid_t       key_asid;

    `include "tlb_ref_model.svh"

    tlb dut (.*);

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic drive_write(input tlb_index_t idx, input vpn2_t vpn2, input asid_t asid,
                               input logic g);
        we      = 1'b1;
        w_index = idx;
        w_vpn2  = vpn2;
        w_asid  = asid;
        w_g     = g;
        {w_pfn0, w_c0, w_d0, w_v0} = 25'($random(seed));
        {w_pfn1, w_c1, w_d1, w_v1} = 25'($random(seed));
    endtask

    // key of a stored entry three times in four
    task automatic pick_key(output vpn2_t vpn2, output asid_t asid);
        tlb_index_t idx;
        idx = tlb_index_t'($random(seed));
        if (($random(seed) & 3) != 0) begin
            vpn2 = shadow[idx].vpn2;
            asid = shadow[idx].asid;
        end else begin
            vpn2 = vpn2_t'($random(seed));
            asid = asid_t'($random(seed));
        end
    endtask

    // outputs checked 10 ns before the edge
    task automatic run_cycle(input string name);
        #80;
        check_value({name, " s0"}, expect_search(s0_vpn2, s0_asid, s0_odd_page),
                    {s0_found, s0_index, s0_pfn, s0_c, s0_d, s0_v});
        check_value({name, " s1"}, expect_search(s1_vpn2, s1_asid, s1_odd_page),
                    {s1_found, s1_index, s1_pfn, s1_c, s1_d, s1_v});
        check_value({name, " read"}, shadow[r_index],
                    {r_vpn2, r_asid, r_g, r_pfn0, r_c0, r_d0, r_v0,
                     r_pfn1, r_c1, r_d1, r_v1});
        @(posedge clk);
        if (!rst) begin
            clear_shadow();
        end else if (we) begin
            shadow[w_index] = {w_vpn2, w_asid, w_g, w_pfn0, w_c0, w_d0, w_v0,
                               w_pfn1, w_c1, w_d1, w_v1};
        end
        #10;
    endtask

    initial begin
        rst = 1'b0;
        we = 1'b0;
        w_index = '0;
        w_vpn2 = '0;
        w_asid = '0;
        w_g = 1'b0;
        {w_pfn0, w_c0, w_d0, w_v0} = '0;
        {w_pfn1, w_c1, w_d1, w_v1} = '0;
        s0_vpn2 = '0;
        s0_asid = '0;
        s0_odd_page = 1'b0;
        s1_vpn2 = '0;
        s1_asid = '0;
        s1_odd_page = 1'b0;
        r_index = '0;
        clear_shadow();
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b1;

        // only key 0/0 hits after reset
        for (int i = 0; i < tlb_num; i++) begin
            r_index = tlb_index_t'(i);
            s1_vpn2 = vpn2_t'($random(seed)) | vpn2_t'(1);
            s1_odd_page = 1'($random(seed));
            run_cycle("reset state");
        end

        // old value stays visible during the write cycle
        repeat (20) begin
            drive_write(tlb_index_t'($random(seed)), vpn2_t'($random(seed)),
                        asid_t'($random(seed)), 1'($random(seed)));
            r_index = w_index;
            run_cycle("write read");
            we = 1'b0;
            run_cycle("read back");
        end

        // low vpn2 nibble equals the index so keys stay distinct
        for (int i = 0; i < tlb_num; i++) begin
            drive_write(tlb_index_t'(i), {15'($random(seed)), tlb_index_t'(i)},
                        asid_t'($random(seed)), 1'($random(seed)));
            s0_vpn2 = w_vpn2;
            s0_asid = w_asid;
            r_index = w_index;
            run_cycle("fill table");
            we = 1'b0;
            run_cycle("fill hit");
        end
        repeat (32) begin
            r_index = tlb_index_t'($random(seed));
            s0_vpn2 = shadow[r_index].vpn2;
            s0_asid = shadow[r_index].asid;
            s1_vpn2 = shadow[~r_index].vpn2;
            s1_asid = shadow[~r_index].asid;
            s0_odd_page = 1'($random(seed));
            s1_odd_page = 1'($random(seed));
            run_cycle("page select");
        end

        // wrong asid misses unless the entry is global
        key_vpn2 = {15'($random(seed)), 4'd3};
        key_asid = asid_t'($random(seed));
        drive_write(4'd3, key_vpn2, key_asid, 1'b0);
        s0_vpn2 = key_vpn2;
        s0_asid = key_asid ^ 8'h01;
        run_cycle("asid write");
        we = 1'b0;
        run_cycle("asid miss");
        drive_write(4'd3, key_vpn2, key_asid, 1'b1);
        run_cycle("global write");
        we = 1'b0;
        run_cycle("global hit");

        // entries 5 and 9 share one key
        key_vpn2 = {15'($random(seed)), 4'd5};
        key_asid = asid_t'($random(seed));
        drive_write(4'd5, key_vpn2, key_asid, 1'b0);
        run_cycle("multi write");
        drive_write(4'd9, key_vpn2, key_asid, 1'b0);
        run_cycle("multi write");
        we = 1'b0;
        s0_vpn2 = key_vpn2;
        s0_asid = key_asid;
        s0_odd_page = 1'b0;
        s1_vpn2 = key_vpn2;
        s1_asid = key_asid;
        s1_odd_page = 1'b1;
        run_cycle("multi hit");

        repeat (400) begin
            if (($random(seed) & 3) == 0) begin
                drive_write(tlb_index_t'($random(seed)), vpn2_t'($random(seed)),
                            asid_t'($random(seed)), 1'($random(seed)));
            end else begin
                we = 1'b0;
            end
            pick_key(s0_vpn2, s0_asid);
            pick_key(s1_vpn2, s1_asid);
            s0_odd_page = 1'($random(seed));
            s1_odd_page = 1'($random(seed));
            r_index = tlb_index_t'($random(seed));
            run_cycle("random mix");
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
source/tlb_pkg.sv
source/tlb_fill_if.sv
source/tlb_slot_if.sv
source/tlb_fill_port.sv
source/tlb_entry.sv
source/tlb_hit_select.sv
source/tlb.sv
sim/tlb_tb.sv

//--- Bender.yml
package:
  name: tlb

sources:
  - files:
      - source/tlb_pkg.sv
      - source/tlb_fill_if.sv
      - source/tlb_slot_if.sv
      - source/tlb_fill_port.sv
      - source/tlb_entry.sv
      - source/tlb_hit_select.sv
      - source/tlb.sv

  - target: test
    include_dirs:
      - include
    files:
      - sim/tlb_tb.sv
